// File: dsp_pkg.sv
package dsp_pkg;

	localparam int lane_count = 4;
	localparam int code_width = 8;
	localparam int ffe_taps = 3;
	localparam int weight_width = 8;
	localparam int ffe_out_width = 10;
	localparam int shift_width = 4;
	localparam int chan_taps = 3;
	localparam int chan_width = 8;
	localparam int err_width = 10;

	// internal sum widths, with headroom for the tap count.
	localparam int ffe_sum_width = code_width + weight_width + 2;
	localparam int chan_sum_width = chan_width + 2;
	localparam int mag_width = err_width + 2;

	localparam int est_max = 2 ** (ffe_out_width - 1) - 1;
	localparam int est_min = -(2 ** (ffe_out_width - 1));
	localparam int code_max = 2 ** (code_width - 1) - 1;
	localparam int code_min = -(2 ** (code_width - 1));

	typedef logic signed [code_width-1:0] code_t;
	typedef logic signed [weight_width-1:0] weight_t;
	typedef logic signed [ffe_out_width-1:0] est_t;
	typedef logic signed [chan_width-1:0] chan_t;
	typedef logic signed [err_width-1:0] err_t;
	typedef logic [shift_width-1:0] shift_t;

	typedef struct packed {
		weight_t [ffe_taps-1:0] weights;
		shift_t ffe_shift;
		est_t thresh;
		chan_t [chan_taps-1:0] chan_est;
		shift_t chan_shift;
	} dsp_cfg_t;

	// lane 0 is the oldest sample of a word.
	typedef struct packed {
		code_t [lane_count-1:0] lane;
	} code_word_t;

	typedef struct packed {
		est_t [lane_count-1:0] lane;
	} est_word_t;

	typedef struct packed {
		logic [lane_count-1:0] lane;
	} bit_word_t;

	typedef struct packed {
		err_t [lane_count-1:0] lane;
	} err_word_t;

	// bit 1 is the large-error flag, bit 0 the flip flag.
	typedef struct packed {
		logic [lane_count-1:0][1:0] lane;
	} flag_word_t;

endpackage : dsp_pkg

// File: ffe_filter.sv
`timescale 1ns/1ps

module ffe_filter (
	input  logic                clk,
	input  logic                rst_i,
	input  dsp_pkg::dsp_cfg_t   cfg_i,
	input  dsp_pkg::code_word_t adc_i,
	output dsp_pkg::est_word_t  est_o,
	output dsp_pkg::bit_word_t  bits_o
);

	import dsp_pkg::*;

	// tail of the previous word, index 0 oldest.
	code_t [ffe_taps-2:0] hist_q;

	code_t [lane_count+ffe_taps-2:0] stream;
	logic signed [ffe_sum_width-1:0] sum [lane_count];
	logic signed [ffe_sum_width-1:0] shifted [lane_count];
	est_word_t est_d;
	bit_word_t bits_d;

	// history first, then the current lanes.
	always_comb begin
		for (int i = 0; i < ffe_taps - 1; i++) begin
			stream[i] = hist_q[i];
		end
		for (int i = 0; i < lane_count; i++) begin
			stream[i+ffe_taps-1] = adc_i.lane[i];
		end
	end

	always_comb begin
		for (int n = 0; n < lane_count; n++) begin
			sum[n] = '0;
			for (int j = 0; j < ffe_taps; j++) begin
				sum[n] = sum[n] + stream[n+ffe_taps-1-j] * cfg_i.weights[j];
			end
			shifted[n] = sum[n] >>> cfg_i.ffe_shift;

			// saturate.
			if (shifted[n] > est_max) begin
				est_d.lane[n] = est_t'(est_max);
			end else if (shifted[n] < est_min) begin
				est_d.lane[n] = est_t'(est_min);
			end else begin
				est_d.lane[n] = est_t'(shifted[n]);
			end

			bits_d.lane[n] = (est_d.lane[n] >= cfg_i.thresh);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			hist_q <= '0;
			est_o <= '0;
			bits_o <= '0;
		end else begin
			for (int i = 0; i < ffe_taps - 1; i++) begin
				hist_q[i] <= adc_i.lane[lane_count-ffe_taps+1+i];
			end
			est_o <= est_d;
			bits_o <= bits_d;
		end
	end

	est_known_a: assert property (
		@(posedge clk) disable iff (rst_i)
		!$isunknown({est_o, bits_o})
	);

endmodule : ffe_filter

// File: channel_filter.sv
`timescale 1ns/1ps

module channel_filter (
	input  logic                clk,
	input  logic                rst_i,
	input  dsp_pkg::dsp_cfg_t   cfg_i,
	input  dsp_pkg::bit_word_t  bits_i,
	output dsp_pkg::code_word_t codes_o
);

	import dsp_pkg::*;

	// last sliced bits of the previous word, index 0 oldest.
	logic [chan_taps-2:0] hist_q;

	logic [lane_count+chan_taps-2:0] stream;
	logic signed [chan_sum_width-1:0] sum [lane_count];
	logic signed [chan_sum_width-1:0] shifted [lane_count];
	code_word_t codes_d;

	always_comb begin
		stream = {bits_i.lane, hist_q};
	end

	always_comb begin
		for (int n = 0; n < lane_count; n++) begin
			sum[n] = '0;
			for (int j = 0; j < chan_taps; j++) begin
				// a one adds the tap, a zero takes it away.
				if (stream[n+chan_taps-1-j]) begin
					sum[n] = sum[n] + cfg_i.chan_est[j];
				end else begin
					sum[n] = sum[n] - cfg_i.chan_est[j];
				end
			end
			shifted[n] = sum[n] >>> cfg_i.chan_shift;

			if (shifted[n] > code_max) begin
				codes_d.lane[n] = code_t'(code_max);
			end else if (shifted[n] < code_min) begin
				codes_d.lane[n] = code_t'(code_min);
			end else begin
				codes_d.lane[n] = code_t'(shifted[n]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			hist_q <= '0;
			codes_o <= '0;
		end else begin
			hist_q <= bits_i.lane[lane_count-1 -: chan_taps-1];
			codes_o <= codes_d;
		end
	end

	// a larger shift would leave nothing of the rebuilt code.
	shift_range_a: assert property (
		@(posedge clk) disable iff (rst_i)
		cfg_i.chan_shift < code_width
	);

endmodule : channel_filter

// File: error_detector.sv
`timescale 1ns/1ps

module error_detector (
	input  logic                clk,
	input  logic                rst_i,
	input  dsp_pkg::dsp_cfg_t   cfg_i,
	input  dsp_pkg::code_word_t adc_i,
	input  dsp_pkg::bit_word_t  bits_i,
	input  dsp_pkg::code_word_t codes_i,
	output dsp_pkg::err_word_t  errs_o,
	output dsp_pkg::flag_word_t flags_o
);

	import dsp_pkg::*;

	typedef logic signed [mag_width-1:0] wide_t;

	function automatic logic [mag_width-1:0] mag(input wide_t v);
		return (v < 0) ? -v : v;
	endfunction

	// align received codes and bits with the rebuilt codes.
	code_word_t adc_d1;
	code_word_t adc_d2;
	bit_word_t bits_d1;

	chan_t h0s;
	logic [mag_width-1:0] h0_mag;
	wide_t flip [lane_count];
	err_word_t errs_d;
	flag_word_t flags_d;

	always_comb begin
		h0s = cfg_i.chan_est[0] >>> cfg_i.chan_shift;
		h0_mag = mag(h0s);

		for (int n = 0; n < lane_count; n++) begin
			errs_d.lane[n] = adc_d2.lane[n] - codes_i.lane[n];

			// error if the decided bit were the other one.
			if (bits_d1.lane[n]) begin
				flip[n] = wide_t'(errs_d.lane[n]) + (wide_t'(h0s) <<< 1);
			end else begin
				flip[n] = wide_t'(errs_d.lane[n]) - (wide_t'(h0s) <<< 1);
			end

			flags_d.lane[n][1] = mag(errs_d.lane[n]) > h0_mag;
			flags_d.lane[n][0] = mag(flip[n]) < mag(errs_d.lane[n]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			adc_d1 <= '0;
			adc_d2 <= '0;
			bits_d1 <= '0;
			errs_o <= '0;
			flags_o <= '0;
		end else begin
			adc_d1 <= adc_i;
			adc_d2 <= adc_d1;
			bits_d1 <= bits_i;
			errs_o <= errs_d;
			flags_o <= flags_d;
		end
	end

	// zero delay line and rebuilt codes give a zero first result.
	reset_clears_a: assert property (
		@(posedge clk) $fell(rst_i) |=> (errs_o == '0 && flags_o == '0)
	);

endmodule : error_detector

// File: datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic                clk,
	input  logic                rst_i,
	input  dsp_pkg::dsp_cfg_t   cfg_i,
	input  dsp_pkg::code_word_t adc_i,
	output dsp_pkg::est_word_t  est_o,
	output dsp_pkg::bit_word_t  bits_o,
	output dsp_pkg::code_word_t codes_o,
	output dsp_pkg::err_word_t  errs_o,
	output dsp_pkg::flag_word_t flags_o
);

	// latency 1.
	ffe_filter ffe_i (
		.clk(clk),
		.rst_i(rst_i),
		.cfg_i(cfg_i),
		.adc_i(adc_i),
		.est_o(est_o),
		.bits_o(bits_o)
	);

	// latency 2.
	channel_filter chan_i (
		.clk(clk),
		.rst_i(rst_i),
		.cfg_i(cfg_i),
		.bits_i(bits_o),
		.codes_o(codes_o)
	);

	// latency 3.
	error_detector err_i (
		.clk(clk),
		.rst_i(rst_i),
		.cfg_i(cfg_i),
		.adc_i(adc_i),
		.bits_i(bits_o),
		.codes_i(codes_o),
		.errs_o(errs_o),
		.flags_o(flags_o)
	);

endmodule : datapath

// File: datapath_model.svh
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

// prev is the word that came just before cur, zero after reset.
function automatic dsp_pkg::est_word_t ffe_estimate(
	input dsp_pkg::dsp_cfg_t cfg,
	input dsp_pkg::code_word_t cur,
	input dsp_pkg::code_word_t prev
);
	dsp_pkg::est_word_t est;
	dsp_pkg::code_t s [2*dsp_pkg::lane_count];
	longint acc;
	for (int i = 0; i < dsp_pkg::lane_count; i++) begin
		s[i] = prev.lane[i];
		s[i+dsp_pkg::lane_count] = cur.lane[i];
	end
	for (int n = 0; n < dsp_pkg::lane_count; n++) begin
		acc = 0;
		for (int j = 0; j < dsp_pkg::ffe_taps; j++) begin
			acc += longint'(s[n+dsp_pkg::lane_count-j]) * longint'(cfg.weights[j]);
		end
		acc = acc >>> cfg.ffe_shift;
		if (acc > dsp_pkg::est_max) begin
			acc = dsp_pkg::est_max;
		end else if (acc < dsp_pkg::est_min) begin
			acc = dsp_pkg::est_min;
		end
		est.lane[n] = dsp_pkg::est_t'(acc);
	end
	return est;
endfunction

function automatic dsp_pkg::bit_word_t slice_bits(
	input dsp_pkg::dsp_cfg_t cfg,
	input dsp_pkg::est_word_t est
);
	dsp_pkg::bit_word_t bits;
	for (int n = 0; n < dsp_pkg::lane_count; n++) begin
		bits.lane[n] = (est.lane[n] >= cfg.thresh);
	end
	return bits;
endfunction

function automatic dsp_pkg::code_word_t rebuild_codes(
	input dsp_pkg::dsp_cfg_t cfg,
	input dsp_pkg::bit_word_t cur,
	input dsp_pkg::bit_word_t prev
);
	dsp_pkg::code_word_t codes;
	logic [2*dsp_pkg::lane_count-1:0] s;
	longint acc;
	s = {cur.lane, prev.lane};
	for (int n = 0; n < dsp_pkg::lane_count; n++) begin
		acc = 0;
		for (int j = 0; j < dsp_pkg::chan_taps; j++) begin
			if (s[n+dsp_pkg::lane_count-j]) begin
				acc += longint'(cfg.chan_est[j]);
			end else begin
				acc -= longint'(cfg.chan_est[j]);
			end
		end
		acc = acc >>> cfg.chan_shift;
		if (acc > dsp_pkg::code_max) begin
			acc = dsp_pkg::code_max;
		end else if (acc < dsp_pkg::code_min) begin
			acc = dsp_pkg::code_min;
		end
		codes.lane[n] = dsp_pkg::code_t'(acc);
	end
	return codes;
endfunction

function automatic dsp_pkg::err_word_t form_errors(
	input dsp_pkg::code_word_t adc,
	input dsp_pkg::code_word_t codes
);
	dsp_pkg::err_word_t errs;
	for (int n = 0; n < dsp_pkg::lane_count; n++) begin
		errs.lane[n] = dsp_pkg::err_t'(longint'(adc.lane[n]) - longint'(codes.lane[n]));
	end
	return errs;
endfunction

// bits is the sliced word that produced the rebuilt codes.
function automatic dsp_pkg::flag_word_t detect_flags(
	input dsp_pkg::dsp_cfg_t cfg,
	input dsp_pkg::err_word_t errs,
	input dsp_pkg::bit_word_t bits
);
	dsp_pkg::flag_word_t flags;
	longint h0;
	longint e;
	longint f;
	h0 = longint'(cfg.chan_est[0]) >>> cfg.chan_shift;
	for (int n = 0; n < dsp_pkg::lane_count; n++) begin
		e = longint'(errs.lane[n]);
		f = bits.lane[n] ? e + 2 * h0 : e - 2 * h0;
		if (e < 0) begin
			e = -e;
		end
		if (f < 0) begin
			f = -f;
		end
		flags.lane[n][1] = e > ((h0 < 0) ? -h0 : h0);
		flags.lane[n][0] = f < e;
	end
	return flags;
endfunction

`endif

// File: tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath;

	import dsp_pkg::*;

	`include "datapath_model.svh"

	localparam int run_count = 4;
	localparam int word_count = 400;
	localparam int reset_cycles = 8;
	localparam int flush_cycles = 3;
	localparam int total_cycles = run_count * (reset_cycles + word_count + flush_cycles + 1);
	localparam int cycle_limit = total_cycles + 20;

	logic clk;
	logic rst_i;
	dsp_cfg_t cfg_i;
	code_word_t adc_i;
	est_word_t est_o;
	bit_word_t bits_o;
	code_word_t codes_o;
	err_word_t errs_o;
	flag_word_t flags_o;

	integer seed;
	int cycle_count = 0;

	est_word_t est_q [$];
	bit_word_t bits_q [$];
	code_word_t codes_q [$];
	err_word_t errs_q [$];
	flag_word_t flags_q [$];

	code_word_t prev_adc;
	bit_word_t prev_bits;

	datapath dut_i (
		.clk(clk),
		.rst_i(rst_i),
		.cfg_i(cfg_i),
		.adc_i(adc_i),
		.est_o(est_o),
		.bits_o(bits_o),
		.codes_o(codes_o),
		.errs_o(errs_o),
		.flags_o(flags_o)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic compare_word(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "output check failed");
		end
	endtask

	task automatic check_outputs();
		compare_word("est_o", est_o, est_q.pop_front());
		compare_word("bits_o", bits_o, bits_q.pop_front());
		compare_word("codes_o", codes_o, codes_q.pop_front());
		compare_word("errs_o", errs_o, errs_q.pop_front());
		compare_word("flags_o", flags_o, flags_q.pop_front());
	endtask

	// mode 0 fixed, mode 1 forces saturation, others random.
	task automatic set_config(input int mode);
		for (int j = 0; j < ffe_taps; j++) begin
			cfg_i.weights[j] = $random(seed);
		end
		cfg_i.ffe_shift = $random(seed);
		cfg_i.thresh = est_t'($random(seed) % 128);
		for (int j = 0; j < chan_taps; j++) begin
			cfg_i.chan_est[j] = $random(seed);
		end
		cfg_i.chan_shift = {$random(seed)} % code_width;
		if (mode == 0) begin
			cfg_i.weights[0] = 8'sd64;
			cfg_i.weights[1] = -8'sd20;
			cfg_i.weights[2] = 8'sd6;
			cfg_i.ffe_shift = 4'd5;
			cfg_i.thresh = '0;
			cfg_i.chan_est[0] = 8'sd60;
			cfg_i.chan_est[1] = 8'sd20;
			cfg_i.chan_est[2] = -8'sd8;
			cfg_i.chan_shift = 4'd1;
		end else if (mode == 1) begin
			for (int j = 0; j < chan_taps; j++) begin
				cfg_i.chan_est[j] = ($random(seed) & 1) ? chan_t'(100 + {$random(seed)} % 28)
					: chan_t'(-100 - {$random(seed)} % 28);
			end
			cfg_i.chan_shift = '0;
			cfg_i.ffe_shift = '0;
		end
	endtask

	// word of random amplitude, with its expected results queued.
	task automatic drive_word();
		code_word_t w;
		est_word_t e;
		bit_word_t b;
		code_word_t c;
		err_word_t er;
		int amp;
		amp = {$random(seed)} % code_width;
		for (int n = 0; n < lane_count; n++) begin
			w.lane[n] = code_t'($random(seed)) >>> amp;
		end
		adc_i = w;
		e = ffe_estimate(cfg_i, w, prev_adc);
		b = slice_bits(cfg_i, e);
		c = rebuild_codes(cfg_i, b, prev_bits);
		er = form_errors(w, c);
		est_q.push_back(e);
		bits_q.push_back(b);
		codes_q.push_back(c);
		errs_q.push_back(er);
		flags_q.push_back(detect_flags(cfg_i, er, b));
		prev_adc = w;
		prev_bits = b;
	endtask

	task automatic run_words(input int mode);
		code_word_t pre_codes;
		err_word_t pre_errs;
		@(negedge clk);
		rst_i = 1'b1;
		adc_i = '0;
		set_config(mode);
		repeat (reset_cycles) @(negedge clk);

		compare_word("est_o", est_o, '0);
		compare_word("bits_o", bits_o, '0);
		compare_word("codes_o", codes_o, '0);
		compare_word("errs_o", errs_o, '0);
		compare_word("flags_o", flags_o, '0);

		est_q.delete();
		bits_q.delete();
		codes_q.delete();
		errs_q.delete();
		flags_q.delete();
		prev_adc = '0;
		prev_bits = '0;

		// first rebuilt codes come from the zero bits held in reset.
		pre_codes = rebuild_codes(cfg_i, '0, '0);
		pre_errs = form_errors('0, pre_codes);
		codes_q.push_back(pre_codes);
		errs_q.push_back('0);
		flags_q.push_back('0);
		errs_q.push_back(pre_errs);
		flags_q.push_back(detect_flags(cfg_i, pre_errs, '0));

		rst_i = 1'b0;
		drive_word();
		for (int k = 1; k <= word_count + flush_cycles; k++) begin
			@(negedge clk);
			check_outputs();
			drive_word();
		end
	endtask

	initial begin
		seed = 32'h4862_029f;
		rst_i = 1'b1;
		cfg_i = '0;
		adc_i = '0;
		prev_adc = '0;
		prev_bits = '0;
		for (int r = 0; r < run_count; r++) begin
			run_words(r);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule : tb_datapath

// File: filelist.f
+incdir+.
dsp_pkg.sv
ffe_filter.sv
channel_filter.sv
error_detector.sv
datapath.sv
tb_datapath.sv

// File: Bender.yml
package:
  name: serdes_rx_eq

sources:
  - dsp_pkg.sv
  - ffe_filter.sv
  - channel_filter.sv
  - error_detector.sv
  - datapath.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_datapath.sv
